// ==== verilog/fib_defines.svh ====
// ====================
// Fibonacci to BCD shared sizes and limits
// ====================

`ifndef FIB_DEFINES_SVH
`define FIB_DEFINES_SVH

// request index and binary result widths
`define FIB_IDX_W   8
`define FIB_VAL_W   14

// F(20) = 6765 is the last term that fits four decimal digits
`define FIB_MAX_IDX 20
`define FIB_SAT_VAL 9999

// result buffer entries, power of two
`define FIFO_DEPTH  4

`endif

// ==== verilog/fib_pkg.sv ====
// ====================
// Fibonacci to BCD result types
// ====================

`default_nettype none

`include "fib_defines.svh"

package fib_pkg;

    // binary result from the producer, saturated above the largest exact index
    typedef struct packed {
        logic [`FIB_VAL_W-1:0] value;
        logic                  overflow;
    } fib_result_t;

    // four packed decimal digits, most significant first
    typedef struct packed {
        logic [3:0] thousands;
        logic [3:0] hundreds;
        logic [3:0] tens;
        logic [3:0] ones;
        logic       overflow;
    } bcd_result_t;

endpackage

`default_nettype wire

// ==== verilog/fib_operator.sv ====
// ====================
// Fibonacci operator: iterates the recurrence for one index,
// saturating indices above 20 to 9999 with overflow
// ====================

`timescale 1ns/1ps
`default_nettype none

`include "fib_defines.svh"

module fib_operator
    (
        input  wire                  i_clk,
        input  wire                  i_rst,
        input  wire                  i_start,
        input  wire [`FIB_IDX_W-1:0] i_gen_amt,
        input  wire                  i_hold,
        output logic                 o_ready,
        output logic                 o_done_tick,
        output fib_pkg::fib_result_t o_result
    );

    localparam int CNT_W = $clog2(`FIB_MAX_IDX + 1);

    typedef enum logic [1:0] {e_idle, e_operate, e_done} t_fib_state;

    t_fib_state            r_state, w_state_next;
    logic [CNT_W-1:0]      r_cnt, w_cnt_next;
    logic [`FIB_VAL_W-1:0] r_temp0, w_temp0_next;
    logic [`FIB_VAL_W-1:0] r_temp1, w_temp1_next;
    logic                  r_ovf, w_ovf_next;

    // control registers
    always_ff @(posedge i_clk, posedge i_rst)
    begin
        if (i_rst)
        begin
            r_state <= e_idle;
            r_cnt   <= '0;
        end
        else
        begin
            r_state <= w_state_next;
            r_cnt   <= w_cnt_next;
        end
    end

    // running terms and flag
    always_ff @(posedge i_clk)
    begin
        r_temp0 <= w_temp0_next;
        r_temp1 <= w_temp1_next;
        r_ovf   <= w_ovf_next;
    end

    always_comb
    begin
        w_state_next = r_state;
        w_cnt_next   = r_cnt;
        w_temp0_next = r_temp0;
        w_temp1_next = r_temp1;
        w_ovf_next   = r_ovf;

        case (r_state)
            e_idle:
            begin
                if (i_start && o_ready)
                begin
                    w_state_next = e_operate;
                    w_ovf_next   = 1'b0;
                    if (i_gen_amt > `FIB_IDX_W'(`FIB_MAX_IDX))
                    begin
                        // saturate, a single pass through operate adds nothing
                        w_temp0_next = '0;
                        w_temp1_next = `FIB_VAL_W'(`FIB_SAT_VAL);
                        w_cnt_next   = CNT_W'(1);
                        w_ovf_next   = 1'b1;
                    end
                    else if (i_gen_amt < `FIB_IDX_W'(2))
                    begin
                        // seed so one add lands on F(0) = 0 or F(1) = 1
                        w_temp0_next = {{(`FIB_VAL_W - 1){1'b0}}, i_gen_amt[0]};
                        w_temp1_next = '0;
                        w_cnt_next   = CNT_W'(2);
                    end
                    else
                    begin
                        w_temp0_next = '0;
                        w_temp1_next = `FIB_VAL_W'(1);
                        w_cnt_next   = i_gen_amt[CNT_W-1:0];
                    end
                end
            end
            e_operate:
            begin
                if (r_cnt == CNT_W'(1))
                begin
                    w_state_next = e_done;
                end
                else
                begin
                    w_temp1_next = r_temp1 + r_temp0;
                    w_temp0_next = r_temp1;
                    w_cnt_next   = r_cnt - CNT_W'(1);
                end
            end
            e_done:
                w_state_next = e_idle;
            default:
                w_state_next = e_idle;
        endcase
    end

    // a full buffer downstream keeps new requests out
    assign o_ready     = (r_state == e_idle) && !i_hold;
    assign o_done_tick = (r_state == e_done);
    assign o_result    = '{value: r_temp1, overflow: r_ovf};

endmodule

`default_nettype wire

// ==== verilog/result_fifo.sv ====
// ====================
// Result FIFO: first-word-fallthrough buffer between the
// Fibonacci producer and the BCD converter
// ====================

`timescale 1ns/1ps
`default_nettype none

`include "fib_defines.svh"

module result_fifo
    #(
        parameter int DEPTH = `FIFO_DEPTH
    )
    (
        input  wire                       i_clk,
        input  wire                       i_rst,
        input  wire                       i_push,
        input  wire fib_pkg::fib_result_t i_data,
        input  wire                       i_pop,
        output fib_pkg::fib_result_t      o_data,
        output logic                      o_empty,
        output logic                      o_full
    );

    import fib_pkg::*;

    localparam int AW = $clog2(DEPTH);

    fib_result_t r_mem [DEPTH];

    // extra msb tells a full buffer from an empty one
    logic [AW:0] r_wr_ptr;
    logic [AW:0] r_rd_ptr;
    logic        w_push;
    logic        w_pop;

    assign w_push = i_push && !o_full;
    assign w_pop  = i_pop && !o_empty;

    always_ff @(posedge i_clk, posedge i_rst)
    begin
        if (i_rst)
        begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
        end
        else
        begin
            if (w_push)
            begin
                r_wr_ptr <= r_wr_ptr + 1'b1;
            end
            if (w_pop)
            begin
                r_rd_ptr <= r_rd_ptr + 1'b1;
            end
        end
    end

    // storage
    always_ff @(posedge i_clk)
    begin
        if (w_push)
        begin
            r_mem[r_wr_ptr[AW-1:0]] <= i_data;
        end
    end

    // head entry falls through without a read cycle
    assign o_data  = r_mem[r_rd_ptr[AW-1:0]];
    assign o_empty = (r_wr_ptr == r_rd_ptr);
    assign o_full  = (r_wr_ptr[AW] != r_rd_ptr[AW]) &&
                     (r_wr_ptr[AW-1:0] == r_rd_ptr[AW-1:0]);

endmodule

`default_nettype wire

// ==== verilog/bin_to_bcd.sv ====
// ====================
// Binary to BCD: pops one result at a time and converts it
// to four decimal digits by shift-and-add-3
// ====================

`timescale 1ns/1ps
`default_nettype none

`include "fib_defines.svh"

module bin_to_bcd
    (
        input  wire                       i_clk,
        input  wire                       i_rst,
        input  wire fib_pkg::fib_result_t i_data,
        input  wire                       i_empty,
        output logic                      o_pop,
        output fib_pkg::bcd_result_t      o_bcd,
        output logic                      o_bcd_valid
    );

    localparam int BCD_W = 16;
    localparam int CNT_W = $clog2(`FIB_VAL_W + 1);

    typedef enum logic [1:0] {e_idle, e_shift, e_done} t_bcd_state;

    t_bcd_state            r_state;
    logic [CNT_W-1:0]      r_cnt;
    logic [`FIB_VAL_W-1:0] r_bin;
    logic [BCD_W-1:0]      r_bcd;
    logic                  r_ovf;
    logic [BCD_W-1:0]      w_bcd_adj;
    logic [BCD_W-1:0]      w_bcd_shift;

    // take the head entry whenever idle and something is queued
    assign o_pop       = (r_state == e_idle) && !i_empty;
    assign o_bcd_valid = (r_state == e_done);

    // add 3 to any digit of 5 or more before the shift
    always_comb
    begin
        w_bcd_adj = r_bcd;
        for (int i = 0; i < BCD_W / 4; i++)
        begin
            if (r_bcd[4*i +: 4] > 4'd4)
            begin
                w_bcd_adj[4*i +: 4] = r_bcd[4*i +: 4] + 4'd3;
            end
        end
    end

    assign w_bcd_shift = {w_bcd_adj[BCD_W-2:0], r_bin[`FIB_VAL_W-1]};

    // one shift per binary bit, then a done cycle
    always_ff @(posedge i_clk, posedge i_rst)
    begin
        if (i_rst)
        begin
            r_state <= e_idle;
            r_cnt   <= '0;
        end
        else
        begin
            case (r_state)
                e_idle:
                begin
                    if (o_pop)
                    begin
                        r_state <= e_shift;
                        r_cnt   <= CNT_W'(`FIB_VAL_W);
                    end
                end
                e_shift:
                begin
                    r_cnt <= r_cnt - CNT_W'(1);
                    if (r_cnt == CNT_W'(1))
                    begin
                        r_state <= e_done;
                    end
                end
                e_done:
                    r_state <= e_idle;
                default:
                    r_state <= e_idle;
            endcase
        end
    end

    // datapath, the output only changes on the final shift
    always_ff @(posedge i_clk)
    begin
        if (o_pop)
        begin
            r_bin <= i_data.value;
            r_ovf <= i_data.overflow;
            r_bcd <= '0;
        end
        else if (r_state == e_shift)
        begin
            r_bin <= {r_bin[`FIB_VAL_W-2:0], 1'b0};
            r_bcd <= w_bcd_shift;
            if (r_cnt == CNT_W'(1))
            begin
                o_bcd.thousands <= w_bcd_shift[15:12];
                o_bcd.hundreds  <= w_bcd_shift[11:8];
                o_bcd.tens      <= w_bcd_shift[7:4];
                o_bcd.ones      <= w_bcd_shift[3:0];
                o_bcd.overflow  <= r_ovf;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/fib_bcd_top.sv ====
// ====================
// Fibonacci to BCD top: producer, result buffer, converter
// ====================

`timescale 1ns/1ps
`default_nettype none

`include "fib_defines.svh"

module fib_bcd_top
    (
        input  wire                  i_clk,
        input  wire                  i_rst,
        input  wire                  i_start,
        input  wire [`FIB_IDX_W-1:0] i_gen_amt,
        output logic                 o_ready,
        output fib_pkg::bcd_result_t o_bcd,
        output logic                 o_bcd_valid
    );

    import fib_pkg::*;

    fib_result_t w_fib_result;
    fib_result_t w_head;
    logic        w_done_tick;
    logic        w_full;
    logic        w_empty;
    logic        w_pop;

    // producer stalls in idle while the buffer is full
    fib_operator u_fib_operator
        (
            .i_clk       (i_clk),
            .i_rst       (i_rst),
            .i_start     (i_start),
            .i_gen_amt   (i_gen_amt),
            .i_hold      (w_full),
            .o_ready     (o_ready),
            .o_done_tick (w_done_tick),
            .o_result    (w_fib_result)
        );

    result_fifo
        #(
            .DEPTH (`FIFO_DEPTH)
        )
    u_result_fifo
        (
            .i_clk   (i_clk),
            .i_rst   (i_rst),
            .i_push  (w_done_tick),
            .i_data  (w_fib_result),
            .i_pop   (w_pop),
            .o_data  (w_head),
            .o_empty (w_empty),
            .o_full  (w_full)
        );

    bin_to_bcd u_bin_to_bcd
        (
            .i_clk       (i_clk),
            .i_rst       (i_rst),
            .i_data      (w_head),
            .i_empty     (w_empty),
            .o_pop       (w_pop),
            .o_bcd       (o_bcd),
            .o_bcd_valid (o_bcd_valid)
        );

endmodule

`default_nettype wire

// ==== dv/fib_bcd_tb.sv ====
// ====================
// Fibonacci to BCD testbench: directed and random requests
// checked against a reference queue
// ====================

`timescale 1ns/1ps
`default_nettype none

`include "fib_defines.svh"

module fib_bcd_tb;

    import fib_pkg::*;

    localparam int CLK_PERIOD     = 100;
    localparam int RST_CYCLES     = 8;
    localparam int DRIVE_DELAY    = 1;
    localparam int N_RANDOM       = 40;
    localparam int N_REQUESTS     = (`FIB_MAX_IDX + 1) + 3 + N_RANDOM;
    localparam int TIMEOUT_CYCLES = N_REQUESTS * (21 + 15 + `FIFO_DEPTH) * 2;

    logic                  i_clk;
    logic                  i_rst;
    logic                  i_start;
    logic [`FIB_IDX_W-1:0] i_gen_amt;
    logic                  o_ready;
    bcd_result_t           o_bcd;
    logic                  o_bcd_valid;

    // accepted request indices in arrival order
    logic [`FIB_IDX_W-1:0] ref_q[$];
    logic [31:0]           lcg_state;
    logic                  rst_prev = 1'b1;
    logic                  hold_seen = 1'b0;
    int                    value_errors = 0;
    int                    protocol_errors = 0;
    int                    end_errors = 0;
    int                    cycle_cnt = 0;
    int                    n_accepted = 0;
    int                    n_valid = 0;
    // edges left until the producer is back in idle
    int                    busy_left = 0;

    fib_bcd_top DUT
        (
            .i_clk       (i_clk),
            .i_rst       (i_rst),
            .i_start     (i_start),
            .i_gen_amt   (i_gen_amt),
            .o_ready     (o_ready),
            .o_bcd       (o_bcd),
            .o_bcd_valid (o_bcd_valid)
        );

    initial
    begin
        i_clk = 1'b0;
    end

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        begin
            return state * 32'd1664525 + 32'd1013904223;
        end
    endfunction

    // F(n) by plain iteration and saturated past the largest exact index
    function automatic int fib_ref_value(input int n);
        int a;
        int b;
        int t;
        begin
            if (n > `FIB_MAX_IDX)
            begin
                return `FIB_SAT_VAL;
            end
            a = 0;
            b = 1;
            for (int k = 0; k < n; k++)
            begin
                t = a + b;
                a = b;
                b = t;
            end
            return a;
        end
    endfunction

    function automatic bcd_result_t expected_bcd(input logic [`FIB_IDX_W-1:0] idx);
        int          v;
        bcd_result_t e;
        begin
            v           = fib_ref_value(int'(idx));
            e.thousands = 4'((v / 1000) % 10);
            e.hundreds  = 4'((v / 100) % 10);
            e.tens      = 4'((v / 10) % 10);
            e.ones      = 4'(v % 10);
            e.overflow  = (int'(idx) > `FIB_MAX_IDX);
            return e;
        end
    endfunction

    // cycles from an accepted start to the producer's done tick
    function automatic int done_latency(input logic [`FIB_IDX_W-1:0] idx);
        begin
            if (int'(idx) > `FIB_MAX_IDX)
            begin
                return 2;
            end
            if (int'(idx) < 2)
            begin
                return 3;
            end
            return int'(idx) + 1;
        end
    endfunction

    task automatic verify_digit(input string name, input logic [3:0] d);
        begin
            assert (d <= 4'd9)
            else
            begin
                protocol_errors++;
                $display("FAILED t=%0t %s got=%0d expected<=9", $time, name, d);
            end
        end
    endtask

    task automatic compare_result();
        logic [`FIB_IDX_W-1:0] idx;
        bcd_result_t           exp;
        begin
            n_valid++;
            verify_digit("o_bcd.thousands", o_bcd.thousands);
            verify_digit("o_bcd.hundreds", o_bcd.hundreds);
            verify_digit("o_bcd.tens", o_bcd.tens);
            verify_digit("o_bcd.ones", o_bcd.ones);
            if (ref_q.size() == 0)
            begin
                protocol_errors++;
                $display("o_bcd_valid pulsed at t=%0t with no request pending", $time);
            end
            else
            begin
                idx = ref_q.pop_front();
                exp = expected_bcd(idx);
                assert (o_bcd == exp)
                else
                begin
                    value_errors++;
                    $display("FAILED t=%0t o_bcd got=%h%h%h%h/%b expected=%h%h%h%h/%b idx=%0d",
                             $time, o_bcd.thousands, o_bcd.hundreds, o_bcd.tens, o_bcd.ones,
                             o_bcd.overflow, exp.thousands, exp.hundreds, exp.tens, exp.ones,
                             exp.overflow, idx);
                end
            end
        end
    endtask

    // sampled at the edge while stimulus changes just after it
    always @(posedge i_clk)
    begin
        if (i_rst || rst_prev)
        begin
            assert (o_bcd_valid == 1'b0)
            else
            begin
                protocol_errors++;
                $display("FAILED t=%0t o_bcd_valid got=%b expected=0", $time, o_bcd_valid);
            end
            assert (o_ready == 1'b1)
            else
            begin
                protocol_errors++;
                $display("FAILED t=%0t o_ready got=%b expected=1", $time, o_ready);
            end
        end
        rst_prev = i_rst;
        if (!i_rst)
        begin
            if (o_bcd_valid)
            begin
                compare_result();
            end
            if (busy_left > 0)
            begin
                busy_left--;
            end
            // producer is idle here, so a low ready can only come from a full buffer
            if (busy_left == 0 && !o_ready)
            begin
                hold_seen = 1'b1;
            end
            if (i_start && o_ready)
            begin
                ref_q.push_back(i_gen_amt);
                n_accepted++;
                busy_left = done_latency(i_gen_amt) + 1;
            end
        end
    end

    valid_one_cycle: assert property (@(posedge i_clk) disable iff (i_rst)
                                      o_bcd_valid |=> !o_bcd_valid)
    else
    begin
        protocol_errors++;
        $display("FAILED t=%0t o_bcd_valid got=1 expected=0 after a valid cycle", $time);
    end

    // the producer leaves idle once it takes a request
    busy_after_start: assert property (@(posedge i_clk) disable iff (i_rst)
                                       (i_start && o_ready) |=> !o_ready)
    else
    begin
        protocol_errors++;
        $display("FAILED t=%0t o_ready got=1 expected=0 after an accepted start", $time);
    end

    task automatic print_error_counts();
        begin
            $display("errors: value %0d, protocol %0d, end of run %0d; valid %0d, accepted %0d",
                     value_errors, protocol_errors, end_errors, n_valid, n_accepted);
        end
    endtask

    always @(posedge i_clk)
    begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("timeout after %0d cycles with %0d results still pending",
                     cycle_cnt, ref_q.size());
            print_error_counts();
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic send_request(input logic [`FIB_IDX_W-1:0] idx);
        begin
            while (!o_ready)
            begin
                @(posedge i_clk);
                #DRIVE_DELAY;
            end
            i_start   = 1'b1;
            i_gen_amt = idx;
            @(posedge i_clk);
            #DRIVE_DELAY;
            i_start = 1'b0;
        end
    endtask

    task automatic wait_for_drain();
        begin
            while (ref_q.size() != 0)
            begin
                @(posedge i_clk);
                #DRIVE_DELAY;
            end
        end
    endtask

    initial
    begin
        i_rst     = 1'b0;
        i_start   = 1'b0;
        i_gen_amt = '0;
        lcg_state = 32'he728_3bea;
        // a rising edge so the asynchronous reset takes effect
        #DRIVE_DELAY;
        i_rst = 1'b1;
        repeat (RST_CYCLES) @(posedge i_clk);
        #DRIVE_DELAY;
        i_rst = 1'b0;

        // exact values with one request in flight at a time
        for (int n = 0; n <= `FIB_MAX_IDX; n++)
        begin
            send_request(8'(n));
            wait_for_drain();
        end

        send_request(8'd21);
        wait_for_drain();
        send_request(8'd100);
        wait_for_drain();
        send_request(8'd255);
        wait_for_drain();

        // back-to-back load where about a third of the indices saturate
        for (int r = 0; r < N_RANDOM; r++)
        begin
            lcg_state = lcg_next(lcg_state);
            send_request({3'b000, lcg_state[20:16]});
        end
        wait_for_drain();
        // catch any stray valid pulse
        repeat (20) @(posedge i_clk);
        #DRIVE_DELAY;

        assert (hold_seen)
        else
        begin
            end_errors++;
            $display("o_ready was never held low by a full result buffer");
        end
        assert (n_valid == n_accepted)
        else
        begin
            end_errors++;
            $display("FAILED t=%0t o_bcd_valid pulse count got=%0d expected=%0d",
                     $time, n_valid, n_accepted);
        end

        print_error_counts();
        if (value_errors + protocol_errors + end_errors == 0)
        begin
            $display("=== PASS ===");
        end
        else
        begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+verilog
verilog/fib_pkg.sv
verilog/fib_operator.sv
verilog/result_fifo.sv
verilog/bin_to_bcd.sv
verilog/fib_bcd_top.sv
dv/fib_bcd_tb.sv

// ==== Makefile ====
# Verilator build and run for the Fibonacci to BCD project

VERILATOR ?= verilator
TOP       ?= fib_bcd_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=
FAIL_MSG  ?= === FAIL ===

COMMON_FLAGS := --timing --assert --timescale 1ns/1ps --top-module $(TOP)
SRCS         := $(shell grep -v '^+' $(FILELIST))
HDRS         := verilog/fib_defines.svh

.PHONY: all run build lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) --binary $(COMMON_FLAGS) -Mdir $(BUILD_DIR) -f $(FILELIST) $(VFLAGS)

run: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only $(COMMON_FLAGS) -f $(FILELIST) $(VFLAGS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
